//--- rtl/edm_cfg.svh
`ifndef EDM_CFG_SVH
`define EDM_CFG_SVH

// clock and dead time
`define EDM_TICKS_PER_US 100 // 100 MHz tick
`define EDM_DEAD_TIME 10 // ticks between opposite switches of one leg

// breakdown wait and protection
`define EDM_WAIT_MAX 5000 // longest gap bias before giving up
`define EDM_CUR_LIMIT 76 // overcurrent trip level
`define EDM_BD_CUR 10 // gap current needed for breakdown
`define EDM_BD_VOL 40 // gap voltage must drop to this or below
`define EDM_BD_TIME 10 // consecutive qualifying samples

// open-loop buck profile
`define EDM_BUCK_PERIOD 400 // 4 us switching period
`define EDM_RISE_CHARGE 120 // charge ticks while current builds up
`define EDM_STAND_CHARGE 80 // charge ticks once current stands
`define EDM_RISE_CYCLES 3 // periods run at the rise charge time

`endif

//--- rtl/edm_pkg.sv
package edm_pkg;

	typedef logic signed [15:0] sample_t; // adc reading, current or voltage
	typedef logic [15:0] time_us_t; // ton / toff in microseconds
	typedef logic [31:0] tick_t; // state and filter timers
	typedef logic [15:0] period_t; // position within a buck period
	typedef logic [1:0] leg_t; // {upper gate, lower gate}

	// gate pair encodings
	localparam leg_t LEG_UP = 2'b10; // upper switch conducting
	localparam leg_t LEG_DN = 2'b01; // lower switch conducting
	localparam leg_t LEG_OFF = 2'b00; // both off, dead time

	// pulse cycle: off time, gap bias, discharge
	typedef enum logic [1:0]
	{
		S_DEION,
		S_WAIT_BREAKDOWN,
		S_BUCK,
		S_RES
	} seq_state_t;

endpackage

//--- rtl/discharge_if.sv
interface discharge_if;

	edm_pkg::seq_state_t state; // sequencer phase
	logic operating; // machine on and no overcurrent
	logic breakdown; // gap has broken down
	edm_pkg::leg_t buck_leg1; // phase 0 gate pair
	edm_pkg::leg_t buck_leg2; // phase 180 gate pair

	modport seq (output state, input operating, input breakdown,
		input buck_leg1, input buck_leg2);

	modport mon (input state, output operating, output breakdown);

	modport buck (input state, output buck_leg1, output buck_leg2);

endinterface

//--- rtl/adc_monitor.sv
`include "edm_cfg.svh"

module adc_monitor
(
	input logic clk,
	input logic rst_n,
	input logic machine_on,
	input edm_pkg::sample_t sample_current,
	input edm_pkg::sample_t sample_voltage,
	discharge_if.mon bus,
	output logic is_operation,
	output logic is_breakdown
);

	edm_pkg::sample_t cur_q; // registered gap current
	edm_pkg::sample_t vol_q; // registered gap voltage
	edm_pkg::tick_t bd_cnt; // consecutive qualifying samples
	logic overcurrent;
	logic bd_qual;
	logic waiting;

	always_ff @(posedge clk)
	begin
		cur_q <= sample_current;
		vol_q <= sample_voltage;
	end

	assign overcurrent = cur_q > `EDM_CUR_LIMIT; // trips on the registered sample
	assign bd_qual = (cur_q >= `EDM_BD_CUR) && (vol_q <= `EDM_BD_VOL); // current flows, voltage collapsed
	assign waiting = bus.state == edm_pkg::S_WAIT_BREAKDOWN;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			is_operation <= 1'b0;
		else
			is_operation <= machine_on && !overcurrent; // two cycles after the sample
	end

	// filter only counts while the gap is biased; a failing sample restarts it
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			bd_cnt <= '0;
			is_breakdown <= 1'b0;
		end
		else if (!waiting)
		begin
			bd_cnt <= '0; // clears one cycle after leaving the wait
			is_breakdown <= 1'b0;
		end
		else if (!bd_qual)
			bd_cnt <= '0;
		else if (bd_cnt >= `EDM_BD_TIME - 1)
			is_breakdown <= 1'b1; // held until the wait ends
		else
			bd_cnt <= bd_cnt + 1'b1;
	end

	assign bus.operating = is_operation;
	assign bus.breakdown = is_breakdown;

endmodule

//--- rtl/pulse_sequencer.sv
`include "edm_cfg.svh"

module pulse_sequencer
(
	input logic clk,
	input logic rst_n,
	input logic res_mode,
	input edm_pkg::time_us_t ton_us,
	input edm_pkg::time_us_t toff_us,
	discharge_if.seq bus,
	output edm_pkg::leg_t mosfet_buck1,
	output edm_pkg::leg_t mosfet_buck2,
	output edm_pkg::leg_t mosfet_res1,
	output edm_pkg::leg_t mosfet_res2,
	output logic mosfet_deion
);

	edm_pkg::seq_state_t state_q;
	edm_pkg::seq_state_t state_d;
	edm_pkg::tick_t timer; // ticks spent in the current state
	edm_pkg::tick_t ton_ticks;
	edm_pkg::tick_t toff_ticks;
	logic head_win; // first dead-time window of the off time
	logic tail_win; // last dead-time window before the gap bias

	// an upper switch that is on must pass through off
	function automatic edm_pkg::leg_t quench(input edm_pkg::leg_t leg);
		if (leg == edm_pkg::LEG_UP)
			return edm_pkg::LEG_OFF;
		return leg;
	endfunction

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ton_ticks <= '0;
			toff_ticks <= '0;
		end
		else
		begin
			ton_ticks <= edm_pkg::tick_t'(ton_us) * `EDM_TICKS_PER_US;
			toff_ticks <= edm_pkg::tick_t'(toff_us) * `EDM_TICKS_PER_US;
		end
	end

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			edm_pkg::S_DEION:
				if (timer + 1'b1 >= toff_ticks && bus.operating)
					state_d = edm_pkg::S_WAIT_BREAKDOWN;
			edm_pkg::S_WAIT_BREAKDOWN:
				if (bus.breakdown && bus.operating)
					state_d = res_mode ? edm_pkg::S_RES : edm_pkg::S_BUCK;
				else if (timer + 1'b1 >= `EDM_WAIT_MAX || !bus.operating)
					state_d = edm_pkg::S_DEION; // no breakdown so start over
			edm_pkg::S_BUCK:
				if (timer + 1'b1 >= ton_ticks)
					state_d = edm_pkg::S_DEION; // buck runs out its ton even on overcurrent
			edm_pkg::S_RES:
				if (timer + 1'b1 >= ton_ticks || !bus.operating)
					state_d = edm_pkg::S_DEION;
			default:
				state_d = edm_pkg::S_DEION;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state_q <= edm_pkg::S_DEION;
			timer <= '0;
		end
		else
		begin
			state_q <= state_d;
			timer <= (state_d != state_q) ? '0 : timer + 1'b1; // restart on every change
		end
	end

	assign head_win = timer < `EDM_DEAD_TIME;
	assign tail_win = timer + `EDM_DEAD_TIME >= toff_ticks; // also holds while off time is extended

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			mosfet_buck1 <= edm_pkg::LEG_OFF;
			mosfet_buck2 <= edm_pkg::LEG_OFF;
			mosfet_res1 <= edm_pkg::LEG_OFF;
			mosfet_res2 <= edm_pkg::LEG_OFF;
			mosfet_deion <= 1'b0;
		end
		else
		begin
			case (state_q)
				edm_pkg::S_DEION:
				begin
					if (head_win)
					begin
						// res1 may still be biased from the wait or discharge
						mosfet_buck1 <= quench(mosfet_buck1);
						mosfet_buck2 <= quench(mosfet_buck2);
						mosfet_res1 <= quench(mosfet_res1);
						mosfet_res2 <= quench(mosfet_res2);
						mosfet_deion <= 1'b0;
					end
					else if (tail_win)
					begin
						mosfet_buck1 <= edm_pkg::LEG_OFF; // open all before the bias
						mosfet_buck2 <= edm_pkg::LEG_OFF;
						mosfet_res1 <= edm_pkg::LEG_OFF;
						mosfet_res2 <= edm_pkg::LEG_OFF;
						mosfet_deion <= 1'b0;
					end
					else
					begin
						mosfet_buck1 <= edm_pkg::LEG_DN; // freewheel low side
						mosfet_buck2 <= edm_pkg::LEG_DN;
						mosfet_res1 <= edm_pkg::LEG_DN;
						mosfet_res2 <= edm_pkg::LEG_DN;
						mosfet_deion <= 1'b1; // clamp the gap
					end
				end
				edm_pkg::S_BUCK:
				begin
					mosfet_buck1 <= bus.buck_leg1;
					mosfet_buck2 <= bus.buck_leg2;
					mosfet_res1 <= edm_pkg::LEG_OFF;
					mosfet_res2 <= edm_pkg::LEG_OFF;
					mosfet_deion <= 1'b0;
				end
				default:
				begin
					// wait and resistor discharge both drive the gap through res1
					mosfet_buck1 <= edm_pkg::LEG_OFF;
					mosfet_buck2 <= edm_pkg::LEG_OFF;
					mosfet_res1 <= edm_pkg::LEG_UP;
					mosfet_res2 <= edm_pkg::LEG_OFF;
					mosfet_deion <= 1'b0;
				end
			endcase
		end
	end

	assign bus.state = state_q;

endmodule

//--- rtl/buck_interleave.sv
`include "edm_cfg.svh"

module buck_interleave
(
	input logic clk,
	input logic rst_n,
	discharge_if.buck bus
);

	edm_pkg::period_t cnt0; // phase 0 position in period
	edm_pkg::period_t cnt180; // phase 180 position in period
	edm_pkg::period_t done0; // completed phase 0 periods, saturating
	edm_pkg::period_t done180;
	logic run180; // phase 180 has started
	logic in_buck;

	// rise charge for the first periods, standing charge after
	function automatic edm_pkg::period_t charge_of(input edm_pkg::period_t done);
		if (done < `EDM_RISE_CYCLES)
			return edm_pkg::period_t'(`EDM_RISE_CHARGE);
		return edm_pkg::period_t'(`EDM_STAND_CHARGE);
	endfunction

	// off, charge, off, discharge within one period
	function automatic edm_pkg::leg_t leg_of(input edm_pkg::period_t cnt,
		input edm_pkg::period_t charge);
		if (cnt < `EDM_DEAD_TIME)
			return edm_pkg::LEG_OFF; // low side released
		if (cnt < `EDM_DEAD_TIME + charge)
			return edm_pkg::LEG_UP; // inductor charging
		if (cnt < 2 * `EDM_DEAD_TIME + charge)
			return edm_pkg::LEG_OFF; // high side released
		return edm_pkg::LEG_DN; // inductor discharging into the gap
	endfunction

	assign in_buck = bus.state == edm_pkg::S_BUCK;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cnt0 <= '0;
			cnt180 <= '0;
			done0 <= '0;
			done180 <= '0;
			run180 <= 1'b0;
		end
		else if (!in_buck)
		begin
			cnt0 <= '0;
			cnt180 <= '0;
			done0 <= '0;
			done180 <= '0;
			run180 <= 1'b0;
		end
		else
		begin
			if (cnt0 == `EDM_BUCK_PERIOD - 1)
			begin
				cnt0 <= '0;
				if (done0 < `EDM_RISE_CYCLES)
					done0 <= done0 + 1'b1;
			end
			else
				cnt0 <= cnt0 + 1'b1;

			if (!run180)
				run180 <= cnt0 == `EDM_BUCK_PERIOD / 2 - 1; // starts at half period
			else if (cnt180 == `EDM_BUCK_PERIOD - 1)
			begin
				cnt180 <= '0;
				if (done180 < `EDM_RISE_CYCLES)
					done180 <= done180 + 1'b1;
			end
			else
				cnt180 <= cnt180 + 1'b1;
		end
	end

	assign bus.buck_leg1 = leg_of(cnt0, charge_of(done0));
	assign bus.buck_leg2 = run180 ? leg_of(cnt180, charge_of(done180)) : edm_pkg::LEG_OFF;

endmodule

//--- rtl/edm_pulse_top.sv
module edm_pulse_top
(
	input logic clk,
	input logic rst_n,

	// operator settings
	input logic machine_on,
	input logic res_mode, // 1 resistor discharge, 0 buck
	input edm_pkg::time_us_t ton_us,
	input edm_pkg::time_us_t toff_us,

	// adc
	input edm_pkg::sample_t sample_current,
	input edm_pkg::sample_t sample_voltage,

	// gate drive
	output edm_pkg::leg_t mosfet_buck1,
	output edm_pkg::leg_t mosfet_buck2,
	output edm_pkg::leg_t mosfet_res1,
	output edm_pkg::leg_t mosfet_res2,
	output logic mosfet_deion,

	// indicators
	output logic is_operation,
	output logic is_breakdown
);

	discharge_if bus_i ();

	adc_monitor mon_i
	(
		.clk (clk),
		.rst_n (rst_n),
		.machine_on (machine_on),
		.sample_current (sample_current),
		.sample_voltage (sample_voltage),
		.bus (bus_i.mon),
		.is_operation (is_operation),
		.is_breakdown (is_breakdown)
	);

	pulse_sequencer seq_i
	(
		.clk (clk),
		.rst_n (rst_n),
		.res_mode (res_mode),
		.ton_us (ton_us),
		.toff_us (toff_us),
		.bus (bus_i.seq),
		.mosfet_buck1 (mosfet_buck1),
		.mosfet_buck2 (mosfet_buck2),
		.mosfet_res1 (mosfet_res1),
		.mosfet_res2 (mosfet_res2),
		.mosfet_deion (mosfet_deion)
	);

	buck_interleave buck_i
	(
		.clk (clk),
		.rst_n (rst_n),
		.bus (bus_i.buck)
	);

endmodule

//--- bench/edm_pulse_tb.sv
`include "edm_cfg.svh"

module edm_pulse_tb;

	typedef enum logic [1:0] {OUT_BUCK, OUT_RES, OUT_TIMEOUT, OUT_BLOCKED} outcome_t;

	typedef struct packed
	{
		logic machine_on;
		logic res_mode;
		edm_pkg::time_us_t ton;
		edm_pkg::time_us_t toff;
		logic bd; // gap breaks down under bias
		logic oc; // gap draws overcurrent
		outcome_t outcome;
	} row_t;

	localparam int NUM_ROWS = 7;
	localparam int BD_DELAY = 20; // bias ticks before the gap breaks down

	logic clk;
	logic rst_n;
	logic machine_on;
	logic res_mode;
	edm_pkg::time_us_t ton_us;
	edm_pkg::time_us_t toff_us;
	edm_pkg::sample_t sample_current;
	edm_pkg::sample_t sample_voltage;
	edm_pkg::leg_t mosfet_buck1;
	edm_pkg::leg_t mosfet_buck2;
	edm_pkg::leg_t mosfet_res1;
	edm_pkg::leg_t mosfet_res2;
	logic mosfet_deion;
	logic is_operation;
	logic is_breakdown;

	row_t rows [0:NUM_ROWS-1];
	logic gap_bd; // gap model setting of the current row
	logic gap_oc;
	logic conducting;
	logic [31:0] rng;
	edm_pkg::tick_t bias_cnt; // ticks of wait bias seen by the gap
	edm_pkg::leg_t last_nz [0:3]; // last driven value per leg
	edm_pkg::tick_t zeros [0:3]; // 00 cycles since that value
	edm_pkg::tick_t run_len [0:1][0:63]; // charge runs per buck phase
	edm_pkg::tick_t cur_len [0:1];
	int run_cnt [0:1];

	edm_pulse_top dut_i
	(
		.clk (clk),
		.rst_n (rst_n),
		.machine_on (machine_on),
		.res_mode (res_mode),
		.ton_us (ton_us),
		.toff_us (toff_us),
		.sample_current (sample_current),
		.sample_voltage (sample_voltage),
		.mosfet_buck1 (mosfet_buck1),
		.mosfet_buck2 (mosfet_buck2),
		.mosfet_res1 (mosfet_res1),
		.mosfet_res2 (mosfet_res2),
		.mosfet_deion (mosfet_deion),
		.is_operation (is_operation),
		.is_breakdown (is_breakdown)
	);

	always #4 clk = ~clk; // 8 unit period

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_leg(input string name, input edm_pkg::leg_t got,
		input edm_pkg::leg_t exp);
		if (got !== exp)
			stop_run($sformatf("CHECK FAILED %s got=%h exp=%h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("CHECK FAILED %s got=%h exp=%h", name, got, exp));
	endtask

	task automatic check_count(input string name, input edm_pkg::tick_t got,
		input edm_pkg::tick_t lo, input edm_pkg::tick_t hi);
		if (got < lo || got > hi)
			stop_run($sformatf("CHECK FAILED %s got=%h exp=%h..%h", name, got, lo, hi));
	endtask

	task automatic check_idle_outputs();
		check_leg("mosfet_buck1", mosfet_buck1, edm_pkg::LEG_OFF);
		check_leg("mosfet_buck2", mosfet_buck2, edm_pkg::LEG_OFF);
		check_leg("mosfet_res1", mosfet_res1, edm_pkg::LEG_OFF);
		check_leg("mosfet_res2", mosfet_res2, edm_pkg::LEG_OFF);
		check_bit("mosfet_deion", mosfet_deion, 1'b0);
		check_bit("is_operation", is_operation, 1'b0);
		check_bit("is_breakdown", is_breakdown, 1'b0);
	endtask

	task automatic check_no_charge();
		check_bit("mosfet_buck1 upper", mosfet_buck1[1], 1'b0);
		check_bit("mosfet_buck2 upper", mosfet_buck2[1], 1'b0);
	endtask

	// 10 and 01 on one leg need a gap of 00 in between
	task automatic track_dead(input string name, input edm_pkg::leg_t leg, input int idx);
		if (leg === 2'b11)
			check_leg(name, leg, edm_pkg::LEG_OFF); // shoot-through
		if (leg == edm_pkg::LEG_OFF)
			zeros[idx] = zeros[idx] + 1;
		else
		begin
			if (last_nz[idx] != edm_pkg::LEG_OFF && leg != last_nz[idx])
				check_count({name, " dead time"}, zeros[idx], `EDM_DEAD_TIME, 32'hffff_ffff);
			last_nz[idx] = leg;
			zeros[idx] = '0;
		end
	endtask

	task automatic note_run(input int p, input edm_pkg::leg_t leg);
		if (leg == edm_pkg::LEG_UP)
			cur_len[p] = cur_len[p] + 1;
		else if (cur_len[p] != 0)
		begin
			if (run_cnt[p] < 64)
				run_len[p][run_cnt[p]] = cur_len[p];
			run_cnt[p] = run_cnt[p] + 1;
			cur_len[p] = '0;
		end
	endtask

	// last run of the pulse may be cut by the end of ton
	task automatic check_profile(input int p);
		edm_pkg::tick_t exp;
		if (run_cnt[p] < `EDM_RISE_CYCLES + 2)
			stop_run($sformatf("buck phase %0d gave only %0d charge runs", p, run_cnt[p]));
		for (int i = 0; i < run_cnt[p] - 1 && i < 64; i++)
		begin
			exp = (i < `EDM_RISE_CYCLES) ? `EDM_RISE_CHARGE : `EDM_STAND_CHARGE;
			check_count($sformatf("mosfet_buck%0d run %0d", p + 1, i), run_len[p][i], exp, exp);
		end
	endtask

	task automatic wait_bias();
		while (mosfet_res1 !== edm_pkg::LEG_UP)
			@(negedge clk);
	endtask

	task automatic wait_deion();
		while (mosfet_deion !== 1'b1)
		begin
			check_no_charge();
			@(negedge clk);
		end
	endtask

	// safe point to change settings during the off time clamp or with the machine stopped
	task automatic wait_idle();
		while (mosfet_deion !== 1'b1 && is_operation !== 1'b0)
			@(negedge clk);
	endtask

	task automatic apply_row(input row_t row);
		@(posedge clk);
		gap_bd = row.bd; // gap model picks it up at the next falling edge
		gap_oc = row.oc;
		@(negedge clk);
		machine_on = row.machine_on;
		res_mode = row.res_mode;
		ton_us = row.ton;
		toff_us = row.toff;
	endtask

	task automatic run_buck_row();
		for (int p = 0; p < 2; p++)
		begin
			run_cnt[p] = 0;
			cur_len[p] = '0;
		end
		wait_bias();
		while (mosfet_deion !== 1'b1)
		begin
			note_run(0, mosfet_buck1);
			note_run(1, mosfet_buck2);
			@(negedge clk);
		end
		check_profile(0);
		check_profile(1);
	endtask

	task automatic run_res_row(input edm_pkg::time_us_t ton);
		edm_pkg::tick_t len;
		edm_pkg::tick_t exp;
		exp = edm_pkg::tick_t'(ton) * `EDM_TICKS_PER_US;
		len = '0;
		wait_bias();
		while (is_breakdown !== 1'b1)
		begin
			check_leg("mosfet_buck1", mosfet_buck1, edm_pkg::LEG_OFF);
			check_leg("mosfet_buck2", mosfet_buck2, edm_pkg::LEG_OFF);
			@(negedge clk);
		end
		while (mosfet_res1 === edm_pkg::LEG_UP)
		begin
			len = len + 1;
			check_leg("mosfet_buck1", mosfet_buck1, edm_pkg::LEG_OFF);
			check_leg("mosfet_buck2", mosfet_buck2, edm_pkg::LEG_OFF);
			@(negedge clk);
		end
		check_count("mosfet_res1 discharge", len, exp - 3, exp + 3);
		wait_deion();
	endtask

	task automatic run_timeout_row();
		edm_pkg::tick_t len;
		len = '0;
		wait_bias();
		while (mosfet_res1 === edm_pkg::LEG_UP)
		begin
			len = len + 1;
			check_bit("is_breakdown", is_breakdown, 1'b0);
			check_no_charge();
			@(negedge clk);
		end
		check_count("mosfet_res1 bias", len, `EDM_WAIT_MAX - 3, `EDM_WAIT_MAX + 3);
		wait_deion(); // next off time starts
	endtask

	task automatic run_blocked_row(input edm_pkg::time_us_t toff);
		int k;
		k = 0;
		while (is_operation !== 1'b0 && k < 3)
		begin
			@(negedge clk);
			k++;
		end
		check_bit("is_operation", is_operation, 1'b0);
		repeat (int'(toff) * `EDM_TICKS_PER_US + 100)
		begin
			@(negedge clk);
			check_bit("mosfet_res1 upper", mosfet_res1[1], 1'b0);
			check_no_charge();
		end
	endtask

	// gap model driving the adc samples on the falling edge
	always @(negedge clk)
	begin
		rng = xorshift(rng);
		if (mosfet_deion)
			bias_cnt = '0; // gap deionized
		else if (mosfet_res1 == edm_pkg::LEG_UP)
			bias_cnt = bias_cnt + 1;
		conducting = (gap_bd && bias_cnt >= BD_DELAY) || mosfet_buck1[1] || mosfet_buck2[1];
		if (gap_oc)
		begin
			sample_current = edm_pkg::sample_t'(`EDM_CUR_LIMIT + 10 + rng[3:0]); // short
			sample_voltage = 16'sd100;
		end
		else if (conducting)
		begin
			sample_current = edm_pkg::sample_t'(`EDM_BD_CUR + 10 + rng[3:0]); // 20..35
			sample_voltage = edm_pkg::sample_t'(`EDM_BD_VOL - 20 + rng[3:0]); // arc voltage
		end
		else
		begin
			sample_current = edm_pkg::sample_t'(rng[2:0]); // leakage only
			sample_voltage = edm_pkg::sample_t'(100 + rng[3:0]); // open gap
		end
	end

	always @(negedge clk)
	begin
		if (rst_n)
		begin
			track_dead("mosfet_buck1", mosfet_buck1, 0);
			track_dead("mosfet_buck2", mosfet_buck2, 1);
			track_dead("mosfet_res1", mosfet_res1, 2);
			track_dead("mosfet_res2", mosfet_res2, 3);
		end
	end

	initial
	begin : watchdog
		edm_pkg::tick_t budget;
		#1; // table is loaded at time 0
		budget = 200; // reset and start-up
		for (int i = 0; i < NUM_ROWS; i++)
			budget = budget + (edm_pkg::tick_t'(rows[i].ton) + rows[i].toff)
				* `EDM_TICKS_PER_US + `EDM_WAIT_MAX;
		budget = budget * 2;
		repeat (budget) @(posedge clk);
		stop_run($sformatf("timeout: tests did not finish within %0d cycles", budget));
	end

	initial
	begin : main_seq
		clk = 1'b0;
		rst_n = 1'b0;
		machine_on = 1'b0;
		res_mode = 1'b0;
		ton_us = 16'd10;
		toff_us = 16'd10;
		sample_current = '0;
		sample_voltage = '0;
		gap_bd = 1'b0;
		gap_oc = 1'b0;
		rng = 32'h5265;
		bias_cnt = '0;
		for (int i = 0; i < 4; i++)
		begin
			last_nz[i] = edm_pkg::LEG_OFF;
			zeros[i] = '0;
		end

		// machine_on, res_mode, ton_us, toff_us, breakdown, overcurrent, outcome
		rows[0] = {1'b1, 1'b0, 16'd30, 16'd10, 1'b1, 1'b0, OUT_BUCK};
		rows[1] = {1'b1, 1'b1, 16'd20, 16'd10, 1'b1, 1'b0, OUT_RES};
		rows[2] = {1'b1, 1'b0, 16'd10, 16'd10, 1'b0, 1'b0, OUT_TIMEOUT};
		rows[3] = {1'b0, 1'b0, 16'd10, 16'd10, 1'b1, 1'b0, OUT_BLOCKED}; // machine off
		rows[4] = {1'b1, 1'b1, 16'd15, 16'd8, 1'b1, 1'b0, OUT_RES};
		rows[5] = {1'b1, 1'b0, 16'd20, 16'd8, 1'b1, 1'b1, OUT_BLOCKED}; // overcurrent trip
		rows[6] = {1'b1, 1'b0, 16'd25, 16'd12, 1'b1, 1'b0, OUT_BUCK};

		repeat (4) @(negedge clk);
		check_idle_outputs(); // still in reset
		rst_n = 1'b1;
		@(negedge clk);
		check_idle_outputs();

		for (int r = 0; r < NUM_ROWS; r++)
		begin
			wait_idle();
			apply_row(rows[r]);
			case (rows[r].outcome)
				OUT_BUCK: run_buck_row();
				OUT_RES: run_res_row(rows[r].ton);
				OUT_TIMEOUT: run_timeout_row();
				default: run_blocked_row(rows[r].toff);
			endcase
		end

		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+rtl
rtl/edm_pkg.sv
rtl/discharge_if.sv
rtl/adc_monitor.sv
rtl/pulse_sequencer.sv
rtl/buck_interleave.sv
rtl/edm_pulse_top.sv
bench/edm_pulse_tb.sv
